// File: Makefile
VERILATOR  ?= verilator
TOP        := rv_core_tb
FILELIST   := rv_core.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
PASS_MSG   := ALL TESTS PASSED
SOURCES    := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all sim lint clean

all: sim

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/rv_core.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core import rv_core_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rstn,
    input  logic     i_load_en,
    input  addr_t    i_load_addr,
    input  word_t    i_load_data,
    output addr_t    o_pc_debug,
    output logic     o_insn_vld,
    output logic     o_wb_rd_wren,
    output reg_idx_t o_wb_rd,
    output word_t    o_wb_data
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

    // Fetch
    addr_t pc_q;
    addr_t pc_plus4;
    addr_t pc_next;
    word_t if_instr;
    word_t imem [`RV_IMEM_WORDS];

    // Stage registers
    ifid_t  ifid_q;
    idex_t  idex_q;
    exmem_t exmem_q;
    memwb_t memwb_q;

    // Decode
    ctrl_t    id_ctrl;
    word_t    id_imm;
    word_t    id_rs1_data;
    word_t    id_rs2_data;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;

    // Execute and memory
    word_t ex_alu_data;
    word_t ex_rs2_fwd;
    addr_t ex_br_addr;
    logic  ex_pcsel;
    word_t mem_rdata;
    word_t mem_rd_data;

    // Hazard controls
    fwd_sel_e rs1_sel;
    fwd_sel_e rs2_sel;
    logic     pc_wren;
    logic     ifid_wren;
    logic     idex_bubble;
    logic     flush;

    // Program load, one word per clock
    always_ff @(posedge i_clk) begin
        if (i_load_en) begin
            imem[i_load_addr[IMEM_AW+1:2]] <= i_load_data;
        end
    end

    assign if_instr = imem[pc_q[IMEM_AW+1:2]];
    assign pc_plus4 = pc_q + addr_t'(4);
    assign pc_next  = exmem_q.pcsel ? exmem_q.br_addr : pc_plus4;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            pc_q <= `RV_RESET_PC;
        end else if (pc_wren) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            ifid_q <= '0;
        end else if (flush) begin
            ifid_q <= '0;
        end else if (ifid_wren) begin
            ifid_q.pc       <= pc_q;
            ifid_q.pc_plus4 <= pc_plus4;
            ifid_q.instr    <= if_instr;
        end
    end

    assign id_rs1 = ifid_q.instr[19:15];
    assign id_rs2 = ifid_q.instr[24:20];

    rv_decoder u_decoder (
        .i_instr (ifid_q.instr),
        .o_ctrl  (id_ctrl),
        .o_imm   (id_imm)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_rs1      (id_rs1),
        .i_rs2      (id_rs2),
        .i_rd       (memwb_q.rd),
        .i_rd_wren  (memwb_q.rd_wren),
        .i_rd_data  (memwb_q.rd_data),
        .o_rs1_data (id_rs1_data),
        .o_rs2_data (id_rs2_data)
    );

    // A bubble clears all control so nothing downstream acts on it
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            idex_q <= '0;
        end else if (flush || idex_bubble) begin
            idex_q <= '0;
        end else begin
            idex_q.ctrl     <= id_ctrl;
            idex_q.pc       <= ifid_q.pc;
            idex_q.pc_plus4 <= ifid_q.pc_plus4;
            idex_q.rs1_data <= id_rs1_data;
            idex_q.rs2_data <= id_rs2_data;
            idex_q.imm      <= id_imm;
            idex_q.funct3   <= ifid_q.instr[14:12];
            idex_q.rs1      <= id_rs1;
            idex_q.rs2      <= id_rs2;
            idex_q.rd       <= ifid_q.instr[11:7];
        end
    end

    rv_execute u_execute (
        .i_idex     (idex_q),
        .i_rs1_sel  (rs1_sel),
        .i_rs2_sel  (rs2_sel),
        .i_mem_fwd  (exmem_q.alu_data),
        .i_wb_fwd   (memwb_q.rd_data),
        .o_alu_data (ex_alu_data),
        .o_rs2_fwd  (ex_rs2_fwd),
        .o_br_addr  (ex_br_addr),
        .o_pcsel    (ex_pcsel)
    );

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            exmem_q <= '0;
        end else if (flush) begin
            exmem_q <= '0;
        end else begin
            exmem_q.ctrl     <= idex_q.ctrl;
            exmem_q.pc       <= idex_q.pc;
            exmem_q.alu_data <= ex_alu_data;
            exmem_q.st_data  <= ex_rs2_fwd;
            exmem_q.br_addr  <= ex_br_addr;
            exmem_q.pcsel    <= ex_pcsel;
            exmem_q.rd       <= idex_q.rd;
        end
    end

    rv_data_mem u_data_mem (
        .i_clk   (i_clk),
        .i_wren  (exmem_q.ctrl.mem_wren),
        .i_rden  (exmem_q.ctrl.mem_rden),
        .i_addr  (exmem_q.alu_data),
        .i_wdata (exmem_q.st_data),
        .o_rdata (mem_rdata)
    );

    assign mem_rd_data = exmem_q.ctrl.wb_sel ? mem_rdata : exmem_q.alu_data;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            memwb_q <= '0;
        end else begin
            memwb_q.insn_vld <= exmem_q.ctrl.insn_vld;
            memwb_q.rd_wren  <= exmem_q.ctrl.rd_wren;
            memwb_q.pc       <= exmem_q.pc;
            memwb_q.rd       <= exmem_q.rd;
            memwb_q.rd_data  <= mem_rd_data;
        end
    end

    rv_hazard_unit u_hazard_unit (
        .i_id_rs1      (id_rs1),
        .i_id_rs2      (id_rs2),
        .i_ex_rd       (idex_q.rd),
        .i_mem_rd      (exmem_q.rd),
        .i_wb_rd       (memwb_q.rd),
        .i_ex_rs1      (idex_q.rs1),
        .i_ex_rs2      (idex_q.rs2),
        .i_ex_mem_rden (idex_q.ctrl.mem_rden),
        .i_mem_rd_wren (exmem_q.ctrl.rd_wren),
        .i_wb_rd_wren  (memwb_q.rd_wren),
        .i_mem_pcsel   (exmem_q.pcsel),
        .o_rs1_sel     (rs1_sel),
        .o_rs2_sel     (rs2_sel),
        .o_pc_wren     (pc_wren),
        .o_ifid_wren   (ifid_wren),
        .o_idex_bubble (idex_bubble),
        .o_flush       (flush)
    );

    // Commit port
    assign o_pc_debug   = memwb_q.pc;
    assign o_insn_vld   = memwb_q.insn_vld;
    assign o_wb_rd_wren = memwb_q.rd_wren;
    assign o_wb_rd      = memwb_q.rd;
    assign o_wb_data    = memwb_q.rd_data;

    // Wrong-path fetch must not survive a redirect
    ifid_flushed: assert property (@(posedge i_clk) disable iff (!i_rstn)
        flush |=> !id_ctrl.insn_vld);

    // The bubble ends a load-use stall after one cycle
    ifid_held: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (!ifid_wren && !flush) |=> ifid_wren);

endmodule

// File: rtl/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Integer datapath width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NUM_REGS 32

// Instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 256

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rtl/rv_core_pkg.sv
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]             word_t;
    typedef logic [`RV_XLEN-1:0]             addr_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [2:0]                      funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic {
        OPA_RS1,
        OPA_PC
    } opa_sel_e;

    typedef enum logic [1:0] {
        OPB_RS2,
        OPB_IMM,
        OPB_PC4
    } opb_sel_e;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic     insn_vld;
        logic     rd_wren;
        logic     mem_wren;
        logic     mem_rden;
        logic     wb_sel;    // 1 selects load data for writeback
        logic     is_br;
        logic     is_jal;
        logic     is_jalr;
        opa_sel_e opa_sel;
        opb_sel_e opb_sel;
        alu_op_e  alu_op;
    } ctrl_t;

    typedef struct packed {
        addr_t pc;
        addr_t pc_plus4;
        word_t instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t    ctrl;
        addr_t    pc;
        addr_t    pc_plus4;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        funct3_t  funct3;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } idex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        addr_t    pc;
        word_t    alu_data;
        word_t    st_data;
        addr_t    br_addr;
        logic     pcsel;
        reg_idx_t rd;
    } exmem_t;

    typedef struct packed {
        logic     insn_vld;
        logic     rd_wren;
        addr_t    pc;
        reg_idx_t rd;
        word_t    rd_data;
    } memwb_t;

endpackage

// File: rtl/rv_data_mem.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_data_mem import rv_core_pkg::*; (
    input  logic  i_clk,
    input  logic  i_wren,
    input  logic  i_rden,
    input  addr_t i_addr,
    input  word_t i_wdata,
    output word_t o_rdata
);

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    word_t              mem [`RV_DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;

    // Byte address to word index
    assign word_idx = i_addr[DMEM_AW+1:2];

    always_ff @(posedge i_clk) begin
        if (i_wren) begin
            mem[word_idx] <= i_wdata;
        end
    end

    assign o_rdata = i_rden ? mem[word_idx] : '0;

    word_aligned: assert property (@(posedge i_clk)
        (i_wren || i_rden) |-> (i_addr[1:0] == 2'b00));

endmodule

// File: rtl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_core_pkg::*; (
    input  word_t i_instr,
    output ctrl_t o_ctrl,
    output word_t o_imm
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0] opcode;
    logic [6:0] funct7;
    funct3_t    funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'h000};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // alt picks SUB or SRA in the shared funct3 slots
    function automatic alu_op_e alu_from_funct3(funct3_t f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        o_ctrl         = '0;
        o_ctrl.opa_sel = OPA_RS1;
        o_ctrl.opb_sel = OPB_IMM;
        o_ctrl.alu_op  = ALU_ADD;
        o_imm          = imm_i;
        case (opcode)
            OPC_OP: begin
                o_ctrl.opb_sel  = OPB_RS2;
                o_ctrl.insn_vld = (funct7 == 7'b0000000) ||
                                  (funct7 == 7'b0100000 &&
                                   (funct3 == 3'b000 || funct3 == 3'b101));
                o_ctrl.rd_wren  = o_ctrl.insn_vld;
                o_ctrl.alu_op   = alu_from_funct3(funct3, funct7[5]);
            end
            OPC_OP_IMM: begin
                // Shift amounts leave funct7 in the upper immediate bits
                o_ctrl.insn_vld = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                                  (funct3 == 3'b101) ? (funct7 == 7'b0000000 ||
                                                        funct7 == 7'b0100000) : 1'b1;
                o_ctrl.rd_wren  = o_ctrl.insn_vld;
                o_ctrl.alu_op   = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
            end
            OPC_LUI: begin
                o_ctrl.insn_vld = 1'b1;
                o_ctrl.rd_wren  = 1'b1;
                o_ctrl.alu_op   = ALU_PASS_B;
                o_imm           = imm_u;
            end
            OPC_AUIPC: begin
                o_ctrl.insn_vld = 1'b1;
                o_ctrl.rd_wren  = 1'b1;
                o_ctrl.opa_sel  = OPA_PC;
                o_imm           = imm_u;
            end
            OPC_JAL: begin
                o_ctrl.insn_vld = 1'b1;
                o_ctrl.rd_wren  = 1'b1;
                o_ctrl.is_jal   = 1'b1;
                o_ctrl.opb_sel  = OPB_PC4;
                o_ctrl.alu_op   = ALU_PASS_B;
                o_imm           = imm_j;
            end
            OPC_JALR: begin
                o_ctrl.insn_vld = (funct3 == 3'b000);
                o_ctrl.rd_wren  = o_ctrl.insn_vld;
                o_ctrl.is_jalr  = o_ctrl.insn_vld;
                o_ctrl.opb_sel  = OPB_PC4;
                o_ctrl.alu_op   = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                // 010 and 011 have no branch defined
                o_ctrl.insn_vld = (funct3[2:1] != 2'b01);
                o_ctrl.is_br    = o_ctrl.insn_vld;
                o_imm           = imm_b;
            end
            OPC_LOAD: begin
                o_ctrl.insn_vld = (funct3 == 3'b010);
                o_ctrl.rd_wren  = o_ctrl.insn_vld;
                o_ctrl.mem_rden = o_ctrl.insn_vld;
                o_ctrl.wb_sel   = 1'b1;
            end
            OPC_STORE: begin
                o_ctrl.insn_vld = (funct3 == 3'b010);
                o_ctrl.mem_wren = o_ctrl.insn_vld;
                o_imm           = imm_s;
            end
            default: begin
                o_ctrl.insn_vld = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
    input  idex_t    i_idex,
    input  fwd_sel_e i_rs1_sel,
    input  fwd_sel_e i_rs2_sel,
    input  word_t    i_mem_fwd,
    input  word_t    i_wb_fwd,
    output word_t    o_alu_data,
    output word_t    o_rs2_fwd,
    output addr_t    o_br_addr,
    output logic     o_pcsel
);

    word_t      rs1_val;
    word_t      opa;
    word_t      opb;
    logic [4:0] shamt;
    logic       br_taken;

    function automatic word_t fwd_value(fwd_sel_e sel, word_t rf_data);
        case (sel)
            FWD_MEM: return i_mem_fwd;
            FWD_WB:  return i_wb_fwd;
            default: return rf_data;
        endcase
    endfunction

    always_comb begin
        rs1_val   = fwd_value(i_rs1_sel, i_idex.rs1_data);
        o_rs2_fwd = fwd_value(i_rs2_sel, i_idex.rs2_data);
    end

    assign opa = (i_idex.ctrl.opa_sel == OPA_PC) ? i_idex.pc : rs1_val;

    always_comb begin
        case (i_idex.ctrl.opb_sel)
            OPB_IMM: opb = i_idex.imm;
            OPB_PC4: opb = i_idex.pc_plus4;
            default: opb = o_rs2_fwd;
        endcase
    end

    assign shamt = opb[4:0];

    always_comb begin
        case (i_idex.ctrl.alu_op)
            ALU_SUB:    o_alu_data = opa - opb;
            ALU_SLL:    o_alu_data = opa << shamt;
            ALU_SLT:    o_alu_data = word_t'($signed(opa) < $signed(opb));
            ALU_SLTU:   o_alu_data = word_t'(opa < opb);
            ALU_XOR:    o_alu_data = opa ^ opb;
            ALU_SRL:    o_alu_data = opa >> shamt;
            ALU_SRA:    o_alu_data = word_t'($signed(opa) >>> shamt);
            ALU_OR:     o_alu_data = opa | opb;
            ALU_AND:    o_alu_data = opa & opb;
            ALU_PASS_B: o_alu_data = opb;
            default:    o_alu_data = opa + opb;
        endcase
    end

    // Compare uses forwarded register values, never the ALU operands
    always_comb begin
        case (i_idex.funct3)
            3'b000:  br_taken = (rs1_val == o_rs2_fwd);
            3'b001:  br_taken = (rs1_val != o_rs2_fwd);
            3'b100:  br_taken = ($signed(rs1_val) < $signed(o_rs2_fwd));
            3'b101:  br_taken = ($signed(rs1_val) >= $signed(o_rs2_fwd));
            3'b110:  br_taken = (rs1_val < o_rs2_fwd);
            3'b111:  br_taken = (rs1_val >= o_rs2_fwd);
            default: br_taken = 1'b0;
        endcase
    end

    assign o_pcsel = i_idex.ctrl.is_jal || i_idex.ctrl.is_jalr ||
                     (i_idex.ctrl.is_br && br_taken);

    always_comb begin
        o_br_addr = (i_idex.ctrl.is_jalr ? rs1_val : i_idex.pc) + i_idex.imm;
        // JALR target has bit 0 cleared
        if (i_idex.ctrl.is_jalr) begin
            o_br_addr[0] = 1'b0;
        end
    end

endmodule

// File: rtl/rv_hazard_unit.sv
`timescale 1ns/1ps

module rv_hazard_unit import rv_core_pkg::*; (
    input  reg_idx_t i_id_rs1,
    input  reg_idx_t i_id_rs2,
    input  reg_idx_t i_ex_rd,
    input  reg_idx_t i_mem_rd,
    input  reg_idx_t i_wb_rd,
    input  reg_idx_t i_ex_rs1,
    input  reg_idx_t i_ex_rs2,
    input  logic     i_ex_mem_rden,
    input  logic     i_mem_rd_wren,
    input  logic     i_wb_rd_wren,
    input  logic     i_mem_pcsel,
    output fwd_sel_e o_rs1_sel,
    output fwd_sel_e o_rs2_sel,
    output logic     o_pc_wren,
    output logic     o_ifid_wren,
    output logic     o_idex_bubble,
    output logic     o_flush
);

    logic load_use;

    // Youngest producer wins, x0 is never forwarded
    function automatic fwd_sel_e fwd_pick(reg_idx_t src);
        if (src == '0) begin
            return FWD_RF;
        end
        if (i_mem_rd_wren && i_mem_rd == src) begin
            return FWD_MEM;
        end
        if (i_wb_rd_wren && i_wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        o_rs1_sel = fwd_pick(i_ex_rs1);
        o_rs2_sel = fwd_pick(i_ex_rs2);
    end

    // Load data only exists after the memory stage
    assign load_use = i_ex_mem_rden && (i_ex_rd != '0) &&
                      (i_ex_rd == i_id_rs1 || i_ex_rd == i_id_rs2);

    assign o_flush = i_mem_pcsel;

    // A redirect overrides the stall and loads the target
    assign o_pc_wren     = o_flush || !load_use;
    assign o_ifid_wren   = o_flush || !load_use;
    assign o_idex_bubble = load_use && !o_flush;

endmodule

// File: rtl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_regfile import rv_core_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rstn,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_rd,
    input  logic     i_rd_wren,
    input  word_t    i_rd_data,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data
);

    word_t regs [`RV_NUM_REGS];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wren && i_rd != '0) begin
            regs[i_rd] <= i_rd_data;
        end
    end

    // Writeback in the same cycle is seen by decode
    function automatic word_t read_port(reg_idx_t idx);
        if (i_rd_wren && i_rd == idx && idx != '0) begin
            return i_rd_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

    x0_reads_zero: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (i_rs1 == '0 |-> o_rs1_data == '0) and (i_rs2 == '0 |-> o_rs2_data == '0));

endmodule

// File: rv_core.f
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_hazard_unit.sv
rtl/rv_data_mem.sv
rtl/rv_core.sv
verification/rv_core_tb.sv

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

    localparam string TRACE_FILE = "verification/rv_core_trace.txt";

    logic     clk;
    logic     rstn;
    logic     load_en;
    addr_t    load_addr;
    word_t    load_data;
    addr_t    pc_debug;
    logic     insn_vld;
    logic     wb_rd_wren;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // Program image and expected commit sequence
    addr_t    prog_addr[$];
    word_t    prog_data[$];
    addr_t    exp_pc[$];
    logic     exp_wren[$];
    reg_idx_t exp_rd[$];
    word_t    exp_data[$];

    int mismatch_cnt = 0;
    int other_cnt    = 0;
    int commit_idx   = 0;
    int cyc          = 0;

    rv_core u_dut (
        .i_clk        (clk),
        .i_rstn       (rstn),
        .i_load_en    (load_en),
        .i_load_addr  (load_addr),
        .i_load_data  (load_data),
        .o_pc_debug   (pc_debug),
        .o_insn_vld   (insn_vld),
        .o_wb_rd_wren (wb_rd_wren),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycles since reset release
    always @(posedge clk) begin
        if (rstn) begin
            cyc <= cyc + 1;
        end
    end

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected x%0d actual x%0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic read_trace();
        int            fd;
        logic [1023:0] line;
        addr_t         a;
        word_t         d;
        logic          w;
        reg_idx_t      r;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open trace file %s", TRACE_FILE);
            other_cnt++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "I %h %h", a, d) == 2) begin
                prog_addr.push_back(a);
                prog_data.push_back(d);
            end else if ($sscanf(line, "C %h %h %h %h", a, w, r, d) == 4) begin
                exp_pc.push_back(a);
                exp_wren.push_back(w);
                exp_rd.push_back(r);
                exp_data.push_back(d);
            end
        end
        $fclose(fd);
        if (exp_pc.size() == 0) begin
            $display("ERROR: trace holds no expected commits");
            other_cnt++;
        end
    endtask

    // One word per write, random idle gaps between writes
    task automatic load_program();
        int gap;
        for (int i = 0; i < prog_addr.size(); i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = prog_addr[i];
            load_data = prog_data[i];
            @(negedge clk);
            load_en = 1'b0;
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic compare_commit();
        string name;
        if (commit_idx >= exp_pc.size()) begin
            $display("ERROR: unexpected extra commit at pc %h", pc_debug);
            other_cnt++;
            return;
        end
        if (commit_idx == 0 && cyc < 4) begin
            $display("ERROR: first commit after %0d cycles, before the pipeline filled", cyc);
            other_cnt++;
        end
        name = $sformatf("commit%0d", commit_idx);
        check_addr({name, ".pc"}, exp_pc[commit_idx], pc_debug);
        check_flag({name, ".rd_wren"}, exp_wren[commit_idx], wb_rd_wren);
        if (exp_wren[commit_idx]) begin
            check_reg({name, ".rd"}, exp_rd[commit_idx], wb_rd);
            // Value aimed at x0 is discarded
            if (exp_rd[commit_idx] != '0) begin
                check_word({name, ".data"}, exp_data[commit_idx], wb_data);
            end
        end
        commit_idx++;
    endtask

    function automatic void report_counts();
        $display("Summary: %0d mismatches, %0d other errors, %0d of %0d commits seen",
                 mismatch_cnt, other_cnt, commit_idx, exp_pc.size());
    endfunction

    // Outputs change on the rising edge only
    always @(negedge clk) begin
        if (insn_vld) begin
            if (cyc == 0) begin
                $display("ERROR: commit reported while the core is in reset");
                other_cnt++;
            end else begin
                compare_commit();
            end
        end
    end

    initial begin
        rstn      = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(32'hcdda));
        read_trace();
        load_program();
        repeat (4) @(negedge clk);
        rstn = 1'b1;
        while (commit_idx < exp_pc.size()) begin
            @(negedge clk);
        end
        // Quiet period to catch stray commits
        repeat (20) @(negedge clk);
        report_counts();
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cyc > 0);
        repeat (20 * exp_pc.size() + 100) @(posedge clk);
        $display("ERROR: timeout waiting for commits");
        report_counts();
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verification/rv_core_trace.txt
# I <byte address> <instruction word>
# C <pc> <rd_wren> <rd> <rd data>, data ignored for x0 and non-writing commits
I 00000000 00500093
I 00000004 ffd00113
I 00000008 002081b3
I 0000000c 40118233
I 00000010 40125293
I 00000014 0020b333
I 00000018 123453b7
I 0000001c 00001417
I 00000020 04702023
I 00000024 04002483
I 00000028 00148533
I 0000002c 00150013
I 00000030 00208463
I 00000034 00209663
I 00000038 00100593
I 0000003c 00200593
I 00000040 00c0066f
I 00000044 00300593
I 00000048 00400593
I 0000004c 05c006e7
I 00000050 00500593
I 00000054 00600593
I 00000058 00700593
I 0000005c 00300733
C 00000000 1 01 00000005
C 00000004 1 02 fffffffd
C 00000008 1 03 00000002
C 0000000c 1 04 fffffffd
C 00000010 1 05 fffffffe
C 00000014 1 06 00000001
C 00000018 1 07 12345000
C 0000001c 1 08 0000101c
C 00000020 0 00 00000000
C 00000024 1 09 12345000
C 00000028 1 0a 12345005
C 0000002c 1 00 00000000
C 00000030 0 00 00000000
C 00000034 0 00 00000000
C 00000040 1 0c 00000044
C 0000004c 1 0d 00000050
C 0000005c 1 0e 00000002
